//--- logic/blur_params.svh
// blur harness parameters
`ifndef BLUR_PARAMS_SVH
`define BLUR_PARAMS_SVH

// pixel width in bits
`define BLUR_PIX_W 8

// pixels per line, no window crosses a line
`define BLUR_LINE_W 16

// statistics counter width
`define BLUR_CNT_W 16

`endif

//--- logic/blur_pkg.sv
// blur shared types
`default_nettype none

`include "blur_params.svh"

package blur_pkg;

    typedef logic [`BLUR_PIX_W-1:0] pix_t;

    // 1 + 2 + 1 weights need two extra bits
    typedef logic [`BLUR_PIX_W+1:0] acc_t;

    typedef logic [$clog2(`BLUR_LINE_W + 1)-1:0] col_t;

    typedef logic [`BLUR_CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

//--- logic/blur_spec.sv
// behavioural 1-2-1 blur
`timescale 1ns/1ps
`default_nettype none

`include "blur_params.svh"

module blur_spec
    import blur_pkg::*;
(
    input  logic clk,
    input  logic rst_init,
    input  pix_t in_data,
    input  logic in_valid,
    output logic in_ready,
    output pix_t out_data,
    output logic out_valid,
    input  logic out_ready
);

    pix_t p1;  // previous pixel
    pix_t p2;  // previous but one
    col_t col;
    acc_t sum;
    logic accept;
    logic win;

    assign in_ready = !out_valid || out_ready;
    assign accept = in_valid && in_ready;
    assign win = (col >= col_t'(2));

    assign sum = acc_t'(p2) + (acc_t'(p1) << 1) + acc_t'(in_data);

    always_ff @(posedge clk) begin
        if (rst_init) begin
            col <= '0;
        end else if (accept) begin
            col <= (col == col_t'(`BLUR_LINE_W - 1)) ? '0 : col + col_t'(1);
        end
    end

    // tap history, no reset needed
    always_ff @(posedge clk) begin
        if (accept) begin
            p2 <= p1;
            p1 <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            out_valid <= 1'b0;
        end else if (accept && win) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && win) begin
            out_data <= sum[`BLUR_PIX_W+1:2];  // truncating divide by 4
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst_init)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- logic/blur_pipe.sv
// pipelined 1-2-1 blur
//   two stages into a two-entry skid buffer
`timescale 1ns/1ps
`default_nettype none

`include "blur_params.svh"

module blur_pipe
    import blur_pkg::*;
(
    input  logic clk,
    input  logic rst_init,
    input  pix_t in_data,
    input  logic in_valid,
    output logic in_ready,
    output pix_t out_data,
    output logic out_valid,
    input  logic out_ready
);

    pix_t p1;
    pix_t p2;
    col_t col;
    logic accept;
    logic win;

    // stage one
    acc_t s1_outer;
    acc_t s1_mid;
    logic s1_valid;

    // stage two, add and shift straight into the buffer
    acc_t s2_sum;
    pix_t s2_data;

    // skid buffer
    pix_t mem [2];
    logic wr_ptr;
    logic rd_ptr;
    logic [1:0] count;
    logic [1:0] level;
    logic push;
    logic pop;

    assign accept = in_valid && in_ready;
    assign win = (col >= col_t'(2));

    always_ff @(posedge clk) begin
        if (rst_init) begin
            col <= '0;
        end else if (accept) begin
            col <= (col == col_t'(`BLUR_LINE_W - 1)) ? '0 : col + col_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            p2 <= p1;
            p1 <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept && win;  // never stalls, buffer space is reserved
        end
    end

    always_ff @(posedge clk) begin
        if (accept && win) begin
            s1_outer <= acc_t'(p2) + acc_t'(in_data);
            s1_mid <= acc_t'(p1) << 1;
        end
    end

    assign s2_sum = s1_outer + s1_mid;
    assign s2_data = s2_sum[`BLUR_PIX_W+1:2];

    assign push = s1_valid;
    assign pop = out_valid && out_ready;
    assign out_valid = (count != 2'd0);
    assign out_data = mem[rd_ptr];

    // entries held plus the one still in stage one
    assign level = count + 2'(s1_valid);
    assign in_ready = (level < 2'd2) || (level == 2'd2 && pop);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= s2_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + 2'(push) - 2'(pop);
        end
    end

    // in_ready reserved a slot when the pixel was taken
    a_no_overflow: assert property (@(posedge clk) disable iff (rst_init)
        push |-> count != 2'd2);

    a_out_stable: assert property (@(posedge clk) disable iff (rst_init)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- logic/eq_checker.sv
// lockstep fork, join and compare
`timescale 1ns/1ps
`default_nettype none

module eq_checker
    import blur_pkg::*;
(
    input  logic clk,
    input  logic rst_init,
    input  pix_t arg_1_tdata,
    input  logic arg_1_tvalid,
    output logic arg_1_tready,
    output pix_t in_data,
    output logic spec_in_valid,
    output logic pipe_in_valid,
    input  logic spec_in_ready,
    input  logic pipe_in_ready,
    input  pix_t spec_out_data,
    input  pix_t pipe_out_data,
    input  logic spec_out_valid,
    input  logic pipe_out_valid,
    output logic out_ready,
    output pix_t arg_0_tdata,
    output logic arg_0_tvalid,
    input  logic arg_0_tready,
    output logic mismatch,
    output cnt_t match_count,
    output cnt_t mismatch_count
);

    logic both_ready;
    logic xfer;
    logic same;

    // fork: a pixel goes in only when both sides take it
    assign both_ready = spec_in_ready && pipe_in_ready;
    assign arg_1_tready = both_ready;
    assign in_data = arg_1_tdata;
    assign spec_in_valid = arg_1_tvalid && both_ready;
    assign pipe_in_valid = arg_1_tvalid && both_ready;

    // join
    assign arg_0_tvalid = spec_out_valid && pipe_out_valid;
    assign arg_0_tdata = pipe_out_data;
    assign xfer = arg_0_tvalid && arg_0_tready;
    assign out_ready = xfer;  // pops both together

    assign same = (spec_out_data == pipe_out_data);

    always_ff @(posedge clk) begin
        if (rst_init) begin
            match_count <= '0;
            mismatch_count <= '0;
        end else if (xfer) begin
            if (same) begin
                match_count <= match_count + cnt_t'(1);
            end else begin
                mismatch_count <= mismatch_count + cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            mismatch <= 1'b0;
        end else if (xfer && !same) begin
            mismatch <= 1'b1;  // sticky until reset
        end
    end

endmodule

`default_nettype wire

//--- logic/eq_top.sv
// blur equivalence harness
`timescale 1ns/1ps
`default_nettype none

`include "blur_params.svh"

module eq_top
    import blur_pkg::*;
(
    input  logic clk,
    input  logic rst_init,
    input  pix_t arg_1_tdata,
    input  logic arg_1_tvalid,
    output logic arg_1_tready,
    output pix_t arg_0_tdata,
    output logic arg_0_tvalid,
    input  logic arg_0_tready,
    output logic mismatch,
    output cnt_t match_count,
    output cnt_t mismatch_count
);

    pix_t in_data;
    logic spec_in_valid;
    logic pipe_in_valid;
    logic spec_in_ready;
    logic pipe_in_ready;
    pix_t spec_out_data;
    pix_t pipe_out_data;
    logic spec_out_valid;
    logic pipe_out_valid;
    logic out_ready;

    blur_spec u_spec (
        .clk       (clk),
        .rst_init  (rst_init),
        .in_data   (in_data),
        .in_valid  (spec_in_valid),
        .in_ready  (spec_in_ready),
        .out_data  (spec_out_data),
        .out_valid (spec_out_valid),
        .out_ready (out_ready)
    );

    blur_pipe u_pipe (
        .clk       (clk),
        .rst_init  (rst_init),
        .in_data   (in_data),
        .in_valid  (pipe_in_valid),
        .in_ready  (pipe_in_ready),
        .out_data  (pipe_out_data),
        .out_valid (pipe_out_valid),
        .out_ready (out_ready)
    );

    eq_checker u_chk (
        .clk            (clk),
        .rst_init       (rst_init),
        .arg_1_tdata    (arg_1_tdata),
        .arg_1_tvalid   (arg_1_tvalid),
        .arg_1_tready   (arg_1_tready),
        .in_data        (in_data),
        .spec_in_valid  (spec_in_valid),
        .pipe_in_valid  (pipe_in_valid),
        .spec_in_ready  (spec_in_ready),
        .pipe_in_ready  (pipe_in_ready),
        .spec_out_data  (spec_out_data),
        .pipe_out_data  (pipe_out_data),
        .spec_out_valid (spec_out_valid),
        .pipe_out_valid (pipe_out_valid),
        .out_ready      (out_ready),
        .arg_0_tdata    (arg_0_tdata),
        .arg_0_tvalid   (arg_0_tvalid),
        .arg_0_tready   (arg_0_tready),
        .mismatch       (mismatch),
        .match_count    (match_count),
        .mismatch_count (mismatch_count)
    );

endmodule

`default_nettype wire

//--- bench/eq_top_tb.sv
// blur equivalence testbench
`timescale 1ns/1ps
`default_nettype none

`include "blur_params.svh"

module eq_top_tb
    import blur_pkg::*;
();

    localparam int LINE_W = `BLUR_LINE_W;
    localparam int N_PIX = 14 * LINE_W + LINE_W / 2;  // all pixels sent
    localparam int MAX_CYCLES = 40 * N_PIX + 400;

    logic clk;
    logic rst_init;
    pix_t arg_1_tdata;
    logic arg_1_tvalid;
    logic arg_1_tready;
    pix_t arg_0_tdata;
    logic arg_0_tvalid;
    logic arg_0_tready;
    logic mismatch;
    cnt_t match_count;
    cnt_t mismatch_count;

    pix_t in_q[$];   // pixels still to send
    pix_t exp_q[$];  // model outputs still to see
    int seed;
    int cycles = 0;
    int n_checked;   // outputs checked since the last reset
    int n_test;      // outputs seen in the current stream

    eq_top u_dut (
        .clk            (clk),
        .rst_init       (rst_init),
        .arg_1_tdata    (arg_1_tdata),
        .arg_1_tvalid   (arg_1_tvalid),
        .arg_1_tready   (arg_1_tready),
        .arg_0_tdata    (arg_0_tdata),
        .arg_0_tvalid   (arg_0_tvalid),
        .arg_0_tready   (arg_0_tready),
        .mismatch       (mismatch),
        .match_count    (match_count),
        .mismatch_count (mismatch_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", MAX_CYCLES);
            end_with_failure();
        end
    end

    task automatic end_with_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input int exp, input int act);
        assert (act == exp) else begin
            $display("[ERROR] %0t ns %s expected %0d got %0d", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_init = 1'b1;
        arg_1_tvalid = 1'b0;
        arg_0_tready = 1'b1;
        repeat (10) @(negedge clk);
        rst_init = 1'b0;
    endtask

    // queue len pixels of one line and the 1-2-1 results inside it
    task automatic add_line(input int kind, input int val, input int len);
        pix_t line [LINE_W];
        int s;
        for (int i = 0; i < len; i++) begin
            if (kind == 0) begin
                line[i] = pix_t'(val);
            end else begin
                line[i] = pix_t'($random(seed));
            end
            in_q.push_back(line[i]);
        end
        for (int i = 2; i < len; i++) begin
            s = int'(line[i-2]) + 2 * int'(line[i-1]) + int'(line[i]);
            exp_q.push_back(pix_t'(s / 4));  // truncating
        end
    endtask

    // inputs change on the falling edge, handshakes sampled just after
    task automatic run_stream(input logic stall);
        logic held;
        pix_t held_data;
        held = 1'b0;
        held_data = '0;
        n_test = 0;
        while (in_q.size() != 0 || exp_q.size() != 0) begin
            @(negedge clk);
            arg_1_tvalid = (in_q.size() != 0);
            arg_1_tdata = (in_q.size() != 0) ? in_q[0] : '0;
            arg_0_tready = stall ? (($random(seed) & 1) != 0) : 1'b1;
            #1;
            if (held) begin  // stalled last cycle, must not move
                check_eq("arg_0_tvalid", 1, int'(arg_0_tvalid));
                check_eq("arg_0_tdata", int'(held_data), int'(arg_0_tdata));
            end
            held = arg_0_tvalid && !arg_0_tready;
            held_data = arg_0_tdata;
            if (arg_1_tvalid && arg_1_tready) begin
                void'(in_q.pop_front());
            end
            if (arg_0_tvalid && arg_0_tready) begin
                if (exp_q.size() == 0) begin
                    $display("an output arrived after all expected outputs were seen");
                    end_with_failure();
                end
                check_eq("arg_0_tdata", int'(exp_q[0]), int'(arg_0_tdata));
                void'(exp_q.pop_front());
                n_test++;
                n_checked++;
            end
        end
        @(negedge clk);
        arg_1_tvalid = 1'b0;
        arg_0_tready = 1'b1;
        // results trail the input by two cycles at most, later ones are extra
        repeat (4) begin
            #1;
            if (arg_0_tvalid) begin
                n_test++;
            end
            @(negedge clk);
        end
    endtask

    task automatic check_status();
        repeat (2) @(negedge clk);  // counters lag the last transfer
        check_eq("mismatch", 0, int'(mismatch));
        check_eq("mismatch_count", 0, int'(mismatch_count));
        check_eq("match_count", n_checked, int'(match_count));
    endtask

    task automatic test_constant_line();
        add_line(0, 93, LINE_W);
        run_stream(1'b0);
        check_eq("constant line output count", LINE_W - 2, n_test);
    endtask

    task automatic test_random_lines();
        repeat (4) add_line(1, 0, LINE_W);
        run_stream(1'b0);
        check_eq("random lines output count", 4 * (LINE_W - 2), n_test);
    endtask

    task automatic test_back_pressure();
        repeat (6) add_line(1, 0, LINE_W);
        run_stream(1'b1);
        check_eq("back-pressure output count", 6 * (LINE_W - 2), n_test);
    endtask

    // black then white, any mixed window would give a middle value
    task automatic test_line_boundary();
        add_line(0, 0, LINE_W);
        add_line(0, 255, LINE_W);
        run_stream(1'b0);
        check_eq("boundary output count", 2 * (LINE_W - 2), n_test);
    endtask

    task automatic test_reset_mid_line();
        add_line(1, 0, LINE_W / 2);
        run_stream(1'b0);
        check_eq("partial line output count", LINE_W / 2 - 2, n_test);
        apply_reset();
        #1;
        check_eq("match_count", 0, int'(match_count));
        check_eq("mismatch_count", 0, int'(mismatch_count));
        check_eq("arg_0_tvalid", 0, int'(arg_0_tvalid));
        n_checked = 0;
        add_line(1, 0, LINE_W);
        run_stream(1'b0);
        check_eq("line after reset output count", LINE_W - 2, n_test);
        check_status();
    endtask

    initial begin
        seed = 11;
        n_checked = 0;
        n_test = 0;
        rst_init = 1'b1;
        arg_1_tdata = '0;
        arg_1_tvalid = 1'b0;
        arg_0_tready = 1'b0;
        apply_reset();
        test_constant_line();
        test_random_lines();
        test_back_pressure();
        test_line_boundary();
        check_status();
        test_reset_mid_line();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+logic
logic/blur_pkg.sv
logic/blur_spec.sv
logic/blur_pipe.sv
logic/eq_checker.sv
logic/eq_top.sv
bench/eq_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the blur equivalence testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module eq_top_tb -f build.f -o sim_eq_top

# a fatal stop exits nonzero, the log search below gives the verdict
./obj_dir/sim_eq_top > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
